/* hyperram_pkg.sv */
package hyperram_pkg;

    //////////////////////////////
    // Sequencer states
    //////////////////////////////

    // A CA state is the cycle in which that command-address byte is on the bus.
    typedef enum logic [3:0] {
        SEQ_IDLE    = 4'd0,
        SEQ_CA0     = 4'd1,
        SEQ_CA1     = 4'd2,
        SEQ_CA2     = 4'd3,
        SEQ_CA3     = 4'd4,
        SEQ_CA4     = 4'd5,
        SEQ_CA5     = 4'd6,
        SEQ_LATENCY = 4'd7,
        SEQ_DATA    = 4'd8,
        SEQ_DONE    = 4'd9
    } seq_state_e;

    //////////////////////////////
    // Configuration space
    //////////////////////////////

    typedef enum logic [1:0] {
        CFG_LATENCY = 2'd0,
        CFG_FIXED   = 2'd1,
        CFG_COUNT   = 2'd2   // Write clears the transaction count.
    } cfg_addr_e;

    localparam logic [2:0] LATENCY_MIN   = 3'd3;
    localparam logic [2:0] LATENCY_MAX   = 3'd7;
    localparam logic [2:0] LATENCY_RESET = 3'd6;

endpackage

/* hbus_if.sv */
`timescale 1ns/1ps

interface hbus_if;

    logic       ncs;       // Chip select, active low.
    logic [7:0] dq_out;
    logic       dq_oe;
    logic       rwds_out;  // Byte mask during write data.
    logic       rwds_oe;
    logic [7:0] dq_in;
    logic       rwds_in;

    modport seq (
        output ncs,
        output dq_out,
        output dq_oe,
        output rwds_out,
        output rwds_oe,
        input  dq_in,
        input  rwds_in
    );

    modport pads (
        input  ncs,
        input  dq_out,
        input  dq_oe,
        input  rwds_out,
        input  rwds_oe,
        output dq_in,
        output rwds_in
    );

endinterface

/* hyperram_cfg_regs.sv */
`timescale 1ns/1ps

module hyperram_cfg_regs (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    cfg_wr,
    input  hyperram_pkg::cfg_addr_e cfg_addr,
    input  logic [7:0]              cfg_wdata,
    output logic [7:0]              cfg_rdata,
    input  logic                    done,
    output logic [2:0]              latency,
    output logic                    fixed_latency
);

    logic [7:0] count;
    logic [2:0] latency_clamped;

    // Out of range latency values are pulled to the nearest legal count.
    always_comb begin
        if (cfg_wdata < {5'd0, hyperram_pkg::LATENCY_MIN})
            latency_clamped = hyperram_pkg::LATENCY_MIN;
        else if (cfg_wdata > {5'd0, hyperram_pkg::LATENCY_MAX})
            latency_clamped = hyperram_pkg::LATENCY_MAX;
        else
            latency_clamped = cfg_wdata[2:0];
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            latency       <= hyperram_pkg::LATENCY_RESET;
            fixed_latency <= 1'b0;
            count         <= 8'd0;
        end else begin
            if (cfg_wr && cfg_addr == hyperram_pkg::CFG_LATENCY)
                latency <= latency_clamped;
            if (cfg_wr && cfg_addr == hyperram_pkg::CFG_FIXED)
                fixed_latency <= cfg_wdata[0];
            if (cfg_wr && cfg_addr == hyperram_pkg::CFG_COUNT)
                count <= 8'd0;  // A clear wins over a completion in the same cycle.
            else if (done)
                count <= count + 8'd1;
        end
    end

    always_comb begin
        case (cfg_addr)
            hyperram_pkg::CFG_LATENCY: cfg_rdata = {5'd0, latency};
            hyperram_pkg::CFG_FIXED:   cfg_rdata = {7'd0, fixed_latency};
            hyperram_pkg::CFG_COUNT:   cfg_rdata = count;
            default:                   cfg_rdata = 8'd0;
        endcase
    end

endmodule

/* hyperram_sequencer.sv */
`timescale 1ns/1ps

module hyperram_sequencer #(
    parameter int ADDR_BITS = 21
) (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic [ADDR_BITS-1:0] cpu_address,
    input  logic [31:0]          cpu_wdata,
    output logic [31:0]          cpu_rdata,
    input  logic [3:0]           cpu_nwr,
    input  logic                 cpu_req,
    output logic                 cpu_ack,
    input  logic [2:0]           latency,
    input  logic                 fixed_latency,
    output logic                 done,
    hbus_if.seq                  bus
);

    hyperram_pkg::seq_state_e state;

    logic [29:0] word_addr;
    logic        is_read;
    logic        req;
    logic        long_wait;
    logic        byte_valid;
    logic [4:0]  wait_cnt;
    logic [1:0]  byte_cnt;
    logic [1:0]  next_byte;

    assign word_addr  = 30'(cpu_address);
    assign is_read    = (cpu_nwr == 4'b1111);
    assign req        = cpu_req & ~cpu_ack;
    assign long_wait  = bus.rwds_in | fixed_latency;  // Device asks for double latency.
    assign next_byte  = byte_cnt + 2'd1;

    // A read waits for the device strobe before the first byte.
    assign byte_valid = ~is_read | bus.rwds_in | (byte_cnt != 2'd0);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state       <= hyperram_pkg::SEQ_IDLE;
            bus.ncs     <= 1'b1;
            bus.dq_oe   <= 1'b0;
            bus.rwds_oe <= 1'b0;
            cpu_ack     <= 1'b0;
            done        <= 1'b0;
            wait_cnt    <= 5'd0;
            byte_cnt    <= 2'd0;
        end else begin
            done <= 1'b0;
            case (state)
                hyperram_pkg::SEQ_IDLE: begin
                    if (req) begin
                        bus.ncs    <= 1'b0;
                        bus.dq_oe  <= 1'b1;
                        // Read flag, memory space, linear burst, then the top address bits.
                        bus.dq_out <= {is_read, 1'b0, 1'b1, 1'b0, word_addr[29:26]};
                        state      <= hyperram_pkg::SEQ_CA0;
                    end
                end
                hyperram_pkg::SEQ_CA0: begin
                    bus.dq_out <= word_addr[25:18];
                    state      <= hyperram_pkg::SEQ_CA1;
                end
                hyperram_pkg::SEQ_CA1: begin
                    bus.dq_out <= word_addr[17:10];
                    state      <= hyperram_pkg::SEQ_CA2;
                end
                hyperram_pkg::SEQ_CA2: begin
                    bus.dq_out <= word_addr[9:2];
                    state      <= hyperram_pkg::SEQ_CA3;
                end
                hyperram_pkg::SEQ_CA3: begin
                    bus.dq_out <= 8'h00;  // Reserved bits.
                    state      <= hyperram_pkg::SEQ_CA4;
                end
                hyperram_pkg::SEQ_CA4: begin
                    bus.dq_out <= {5'd0, word_addr[1:0], 1'b0};  // Half-word column.
                    state      <= hyperram_pkg::SEQ_CA5;
                end
                hyperram_pkg::SEQ_CA5: begin
                    bus.dq_oe <= 1'b0;
                    // The wait state lasts one cycle longer than the loaded count.
                    if (long_wait)
                        wait_cnt <= {latency, 2'b00} - 5'd2;
                    else
                        wait_cnt <= {1'b0, latency, 1'b0} - 5'd2;
                    state <= hyperram_pkg::SEQ_LATENCY;
                end
                hyperram_pkg::SEQ_LATENCY: begin
                    if (wait_cnt == 5'd0) begin
                        byte_cnt     <= 2'd0;
                        bus.dq_oe    <= ~is_read;
                        bus.rwds_oe  <= ~is_read;
                        bus.dq_out   <= cpu_wdata[7:0];
                        bus.rwds_out <= cpu_nwr[0];
                        state        <= hyperram_pkg::SEQ_DATA;
                    end else begin
                        wait_cnt <= wait_cnt - 5'd1;
                    end
                end
                hyperram_pkg::SEQ_DATA: begin
                    // Queue the following byte for writes.
                    bus.dq_out   <= cpu_wdata[{next_byte, 3'b000} +: 8];
                    bus.rwds_out <= cpu_nwr[next_byte];
                    if (byte_valid) begin
                        if (is_read)
                            cpu_rdata[{byte_cnt, 3'b000} +: 8] <= bus.dq_in;
                        byte_cnt <= next_byte;
                        if (byte_cnt == 2'd3) begin
                            bus.ncs     <= 1'b1;
                            bus.dq_oe   <= 1'b0;
                            bus.rwds_oe <= 1'b0;
                            cpu_ack     <= 1'b1;
                            done        <= 1'b1;
                            state       <= hyperram_pkg::SEQ_DONE;
                        end
                    end
                end
                hyperram_pkg::SEQ_DONE: begin
                    // Hold the acknowledge until the CPU lets go of the request.
                    if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= hyperram_pkg::SEQ_IDLE;
                    end
                end
                default: state <= hyperram_pkg::SEQ_IDLE;
            endcase
        end
    end

endmodule

/* hyperram_pads.sv */
`timescale 1ns/1ps

module hyperram_pads (
    input  logic       clk,
    input  logic       nreset,
    hbus_if.pads       bus,
    output logic       hyperram_clk,
    output logic       hyperram_nreset,
    output logic       hyperram_ncs,
    output logic [7:0] hyperram_data_out,
    output logic       hyperram_data_noe,
    output logic       hyperram_rwds_out,
    output logic       hyperram_rwds_noe,
    input  logic [7:0] hyperram_data_in,
    input  logic       hyperram_rwds_in
);

    assign hyperram_nreset = nreset;
    assign bus.dq_in       = hyperram_data_in;
    assign bus.rwds_in     = hyperram_rwds_in;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            hyperram_ncs      <= 1'b1;
            hyperram_data_noe <= 1'b1;
            hyperram_rwds_noe <= 1'b1;
        end else begin
            hyperram_ncs      <= bus.ncs;
            hyperram_data_noe <= ~bus.dq_oe;  // Pin enables are active low.
            hyperram_rwds_noe <= ~bus.rwds_oe;
        end
    end

    always_ff @(posedge clk) begin
        hyperram_data_out <= bus.dq_out;
        hyperram_rwds_out <= bus.rwds_out;
    end

    // The half-rate bus clock is parked low while the device is deselected.
    always_ff @(negedge clk) begin
        if (!nreset || hyperram_ncs)
            hyperram_clk <= 1'b0;
        else
            hyperram_clk <= ~hyperram_clk;
    end

endmodule

/* hyperram_top.sv */
`timescale 1ns/1ps

module hyperram_top #(
    parameter int ADDR_BITS = 21
) (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic [ADDR_BITS-1:0]    cpu_address,
    input  logic [31:0]             cpu_wdata,
    output logic [31:0]             cpu_rdata,
    input  logic [3:0]              cpu_nwr,
    input  logic                    cpu_req,
    output logic                    cpu_ack,
    input  logic                    cfg_wr,
    input  hyperram_pkg::cfg_addr_e cfg_addr,
    input  logic [7:0]              cfg_wdata,
    output logic [7:0]              cfg_rdata,
    output logic                    hyperram_clk,
    output logic                    hyperram_nreset,
    output logic                    hyperram_ncs,
    output logic [7:0]              hyperram_data_out,
    output logic                    hyperram_data_noe,
    output logic                    hyperram_rwds_out,
    output logic                    hyperram_rwds_noe,
    input  logic [7:0]              hyperram_data_in,
    input  logic                    hyperram_rwds_in
);

    logic [2:0] latency;
    logic       fixed_latency;
    logic       done;

    hbus_if bus ();

    hyperram_cfg_regs u_cfg_regs (
        .clk           (clk),
        .nreset        (nreset),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata),
        .done          (done),
        .latency       (latency),
        .fixed_latency (fixed_latency)
    );

    hyperram_sequencer #(
        .ADDR_BITS (ADDR_BITS)
    ) u_sequencer (
        .clk           (clk),
        .nreset        (nreset),
        .cpu_address   (cpu_address),
        .cpu_wdata     (cpu_wdata),
        .cpu_rdata     (cpu_rdata),
        .cpu_nwr       (cpu_nwr),
        .cpu_req       (cpu_req),
        .cpu_ack       (cpu_ack),
        .latency       (latency),
        .fixed_latency (fixed_latency),
        .done          (done),
        .bus           (bus.seq)
    );

    hyperram_pads u_pads (
        .clk               (clk),
        .nreset            (nreset),
        .bus               (bus.pads),
        .hyperram_clk      (hyperram_clk),
        .hyperram_nreset   (hyperram_nreset),
        .hyperram_ncs      (hyperram_ncs),
        .hyperram_data_out (hyperram_data_out),
        .hyperram_data_noe (hyperram_data_noe),
        .hyperram_rwds_out (hyperram_rwds_out),
        .hyperram_rwds_noe (hyperram_rwds_noe),
        .hyperram_data_in  (hyperram_data_in),
        .hyperram_rwds_in  (hyperram_rwds_in)
    );

endmodule

/* hyperram_dev_model.sv */
`timescale 1ns/1ps

module hyperram_dev_model (
    input  logic       hyperram_clk,
    input  logic       hyperram_ncs,
    input  logic [7:0] hyperram_data_out,
    input  logic       hyperram_rwds_out,
    output logic [7:0] hyperram_data_in,
    output logic       hyperram_rwds_in,
    input  logic [2:0] latency,
    input  logic       double_latency,
    input  logic       fixed_latency
);

    logic [31:0] mem [0:63];
    logic [7:0]  ca [0:5];
    logic [7:0]  rd_byte;
    logic        drive = 1'b0;
    logic [5:0]  index;
    int          step = 0;  // Bus clock edges since chip select fell.
    int          data_start;
    int          byte_idx;

    assign index = {ca[3][3:0], ca[5][2:1]};

    // Data follows the six CA edges and the initial latency, doubled on request.
    assign data_start = 6 + ((double_latency || fixed_latency) ? 4 * latency : 2 * latency) - 1;
    assign byte_idx   = step - data_start;

    assign hyperram_data_in = drive ? rd_byte : 8'h00;
    assign hyperram_rwds_in = !hyperram_ncs && (drive || (step < 6 && double_latency));

    always @(posedge hyperram_ncs) begin
        step  <= 0;
        drive <= 1'b0;
    end

    // Every bus clock edge carries one byte.
    always @(hyperram_clk) begin
        if (hyperram_ncs === 1'b0) begin
            if (step < 6) begin
                ca[step] <= hyperram_data_out;
            end else if (byte_idx >= 0 && byte_idx < 4) begin
                if (ca[0][7]) begin
                    drive   <= 1'b1;
                    rd_byte <= mem[index][8*byte_idx +: 8];
                end else if (!hyperram_rwds_out) begin
                    mem[index][8*byte_idx +: 8] <= hyperram_data_out;  // Low mask writes.
                end
            end else begin
                drive <= 1'b0;
            end
            step <= step + 1;
        end
    end

endmodule

/* hyperram_assert.sv */
`timescale 1ns/1ps

module hyperram_assert (
    input logic clk,
    input logic nreset,
    input logic cpu_req,
    input logic cpu_ack,
    input logic hyperram_ncs,
    input logic hyperram_data_noe,
    input logic hyperram_rwds_noe
);

    int fail_count = 0;

    // Pins stay undriven while the device is deselected.
    enables_off_when_deselected: assert property (@(posedge clk) disable iff (!nreset)
        hyperram_ncs |-> hyperram_data_noe && hyperram_rwds_noe)
    else begin
        $error("Output enable active while hyperram_ncs is high.");
        fail_count++;
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (!nreset)
        $rose(cpu_ack) |-> $past(cpu_req))
    else begin
        $error("cpu_ack rose without cpu_req.");
        fail_count++;
    end

    ack_follows_req: assert property (@(posedge clk) disable iff (!nreset)
        $fell(cpu_req) |=> !cpu_ack)
    else begin
        $error("cpu_ack did not fall the cycle after cpu_req fell.");
        fail_count++;
    end

endmodule

bind hyperram_top hyperram_assert u_assert (.*);

/* tb_hyperram.sv */
`timescale 1ns/1ps

module tb_hyperram;

    localparam int ADDR_BITS = 21;
    localparam int MAX_OPS   = 64;

    logic                    clk;
    logic                    nreset;
    logic [ADDR_BITS-1:0]    cpu_address;
    logic [31:0]             cpu_wdata;
    logic [31:0]             cpu_rdata;
    logic [3:0]              cpu_nwr;
    logic                    cpu_req;
    logic                    cpu_ack;
    logic                    cfg_wr;
    hyperram_pkg::cfg_addr_e cfg_addr;
    logic [7:0]              cfg_wdata;
    logic [7:0]              cfg_rdata;
    logic                    hyperram_clk;
    logic                    hyperram_nreset;
    logic                    hyperram_ncs;
    logic                    hyperram_data_noe;
    logic                    hyperram_rwds_out;
    logic                    hyperram_rwds_noe;
    logic                    hyperram_rwds_in;
    logic [7:0]              hyperram_data_out;
    logic [7:0]              hyperram_data_in;
    logic [2:0]              model_latency;
    logic                    model_double;
    logic                    model_fixed;
    logic [31:0]             stim [0:6*MAX_OPS-1];  // Six words per operation.
    int                      n_ops;

    hyperram_top #(.ADDR_BITS (ADDR_BITS)) i_dut (.*);

    hyperram_dev_model u_model (
        .latency        (model_latency),
        .double_latency (model_double),
        .fixed_latency  (model_fixed),
        .*
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic end_in_failure();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s gave %h, expected %h", $time, what, actual, expected);
            end_in_failure();
        end
    endtask

    function automatic logic [2:0] legal_latency(input logic [31:0] value);
        if (value < 32'd3)
            return 3'd3;
        if (value > 32'd7)
            return 3'd7;
        return value[2:0];
    endfunction

    task automatic cfg_write(input logic [1:0] addr, input logic [7:0] data);
        @(posedge clk);
        #2;
        cfg_addr  = hyperram_pkg::cfg_addr_e'(addr);
        cfg_wdata = data;
        cfg_wr    = 1'b1;
        @(posedge clk);
        #2;
        cfg_wr = 1'b0;
    endtask

    task automatic cfg_read(input logic [1:0] addr, output logic [7:0] data);
        @(posedge clk);
        #2;
        cfg_addr = hyperram_pkg::cfg_addr_e'(addr);
        @(posedge clk);
        #2;
        data = cfg_rdata;
    endtask

    task automatic cpu_access(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] nwr, output logic [31:0] rdata);
        @(posedge clk);
        #2;
        cpu_address = addr[ADDR_BITS-1:0];
        cpu_wdata   = data;
        cpu_nwr     = nwr;
        cpu_req     = 1'b1;
        do begin
            @(posedge clk);
            #2;
        end while (cpu_ack !== 1'b1);
        rdata   = cpu_rdata;  // Read data is valid while the acknowledge is high.
        cpu_req = 1'b0;
        do begin
            @(posedge clk);
            #2;
        end while (cpu_ack !== 1'b0);
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] nwr;
        logic [31:0] expected;
        logic [31:0] rdata;
        logic [7:0]  cfg_value;

        nreset        = 1'b0;
        cpu_address   = '0;
        cpu_wdata     = 32'd0;
        cpu_nwr       = 4'hf;
        cpu_req       = 1'b0;
        cfg_wr        = 1'b0;
        cfg_addr      = hyperram_pkg::CFG_LATENCY;
        cfg_wdata     = 8'd0;
        model_latency = 3'd6;  // Device latency after reset.
        model_double  = 1'b0;
        model_fixed   = 1'b0;
        $readmemh("hyperram_stimulus.txt", stim);
        n_ops = 0;
        while (n_ops < MAX_OPS && !$isunknown(stim[6*n_ops]))
            n_ops++;
        if (n_ops == 0) begin
            $display("No operations could be read from hyperram_stimulus.txt.");
            end_in_failure();
        end
        repeat (4) @(posedge clk);
        #2;
        compare({31'd0, hyperram_nreset}, 32'd0, "hyperram_nreset during reset");
        nreset = 1'b1;

        // Deselected device, both pin enables off and no acknowledge.
        @(posedge clk);
        #2;
        compare({27'd0, hyperram_nreset, hyperram_ncs, hyperram_data_noe,
                 hyperram_rwds_noe, cpu_ack}, 32'h1e, "pin state after reset");

        for (int i = 0; i < n_ops; i++) begin
            op           = stim[6*i];
            model_double = stim[6*i+1][0];
            addr         = stim[6*i+2];
            data         = stim[6*i+3];
            nwr          = stim[6*i+4];
            expected     = stim[6*i+5];
            case (op)
                32'h0: begin
                    cfg_write(addr[1:0], data[7:0]);
                    if (addr == 32'd0)
                        model_latency = legal_latency(data);  // The device follows the host.
                    if (addr == 32'd1)
                        model_fixed = data[0];
                end
                32'h1: begin
                    cfg_read(addr[1:0], cfg_value);
                    compare({24'd0, cfg_value}, expected, $sformatf("config register %0d", addr));
                end
                32'h2: cpu_access(addr, data, nwr[3:0], rdata);
                32'h3: begin
                    cpu_access(addr, data, nwr[3:0], rdata);
                    compare(rdata, expected, $sformatf("CPU read of word %0h", addr));
                end
                default: begin
                    $display("Stimulus line %0d has the unknown operation %0h.", i, op);
                    end_in_failure();
                end
            endcase
        end

        @(posedge clk);
        if (i_dut.u_assert.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("A protocol assertion on the DUT failed.");
            end_in_failure();
        end
    end

    always @(posedge clk) begin
        if (i_dut.u_assert.fail_count != 0) begin
            $display("A protocol assertion on the DUT failed.");
            end_in_failure();
        end
    end

    // The watchdog allows 200 cycles per operation and one more block for reset.
    initial begin
        #1;
        repeat (200 * (n_ops + 1)) @(posedge clk);
        $display("Timeout: the operations did not finish in %0d cycles.", 200 * (n_ops + 1));
        end_in_failure();
    end

endmodule

/* hyperram_stimulus.txt */
// op dbl addr data nwr expected, all hex
// op 0 config write, 1 config read, 2 CPU write, 3 CPU read; dbl is the model's double latency
1 0 0 00000000 0 6
0 0 2 00000000 0 0
2 0 05 11223344 0 0
3 0 05 00000000 f 11223344
2 0 2a a5a55a5a 0 0
3 0 2a 00000000 f a5a55a5a
2 0 3f deadbeef 0 0
2 0 3f 00c0ffee 5 0
3 0 3f 00000000 f 00adffef
1 0 2 00000000 0 7
2 1 10 cafef00d 0 0
3 1 10 00000000 f cafef00d
0 0 1 00000001 0 0
1 0 1 00000000 0 1
3 0 05 00000000 f 11223344
2 0 11 12345678 0 0
3 0 11 00000000 f 12345678
0 0 1 00000000 0 0
0 0 0 00000001 0 0
1 0 0 00000000 0 3
3 0 2a 00000000 f a5a55a5a
3 1 11 00000000 f 12345678
0 0 0 0000000f 0 0
1 0 0 00000000 0 7
2 1 3f 55aa55aa e 0
3 0 3f 00000000 f 00adffaa
1 0 2 00000000 0 10
0 0 2 00000000 0 0
1 0 2 00000000 0 0

/* compile.f */
hyperram_pkg.sv
hbus_if.sv
hyperram_cfg_regs.sv
hyperram_sequencer.sv
hyperram_pads.sv
hyperram_top.sv
hyperram_dev_model.sv
hyperram_assert.sv
tb_hyperram.sv

/* Bender.yml */
package:
  name: hyperram_ctrl

sources:
  - hyperram_pkg.sv
  - hbus_if.sv
  - hyperram_cfg_regs.sv
  - hyperram_sequencer.sv
  - hyperram_pads.sv
  - hyperram_top.sv
  - target: test
    files:
      - hyperram_dev_model.sv
      - hyperram_assert.sv
      - tb_hyperram.sv
